// File: hdl/mini_rv_settings.svh
// mini_rv core settings

`ifndef MINI_RV_SETTINGS_SVH
`define MINI_RV_SETTINGS_SVH

// Data and address width
`define MINI_RV_XLEN 32

// Register index width
`define MINI_RV_REG_ADDR_W 5

// Architectural integer registers, x0 included
`define MINI_RV_NUM_REGS 32

// First fetch address after reset
`define MINI_RV_BOOT_ADDR 32'h0000_0080

`endif

// File: hdl/mini_rv_pkg.sv
// mini_rv shared types

`default_nettype none

`include "mini_rv_settings.svh"

package mini_rv_pkg;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    // LUI and store data
    ALU_PASS_B = 3'd6
  } alu_op_e;

  // What the instruction does in EX
  typedef enum logic [1:0] {
    KIND_ALU   = 2'd0,
    KIND_STORE = 2'd1,
    KIND_NOP   = 2'd2
  } instr_kind_e;

  // Fetch unit states
  typedef enum logic [1:0] {
    FETCH_IDLE = 2'd0,
    FETCH_WAIT = 2'd1,
    FETCH_HOLD = 2'd2
  } fetch_state_e;

  // Wishbone classic master request
  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`MINI_RV_XLEN-1:0] adr;
    logic [3:0]               sel;
    logic [`MINI_RV_XLEN-1:0] dat;
  } wb_m2s_t;

  // Wishbone classic slave response
  typedef struct packed {
    logic                     ack;
    logic [`MINI_RV_XLEN-1:0] dat;
  } wb_s2m_t;

  // IF/ID register contents
  typedef struct packed {
    logic [`MINI_RV_XLEN-1:0] instr;
    logic [`MINI_RV_XLEN-1:0] pc;
  } if_id_pipe_t;

  // ID/EX register contents, operands already forwarded
  typedef struct packed {
    instr_kind_e                    kind;
    alu_op_e                        alu_op;
    logic [`MINI_RV_XLEN-1:0]       operand_a;
    logic [`MINI_RV_XLEN-1:0]       operand_b;
    logic [`MINI_RV_XLEN-1:0]       store_data;
    logic [`MINI_RV_XLEN-1:0]       store_offset;
    logic [`MINI_RV_REG_ADDR_W-1:0] rd;
  } id_ex_pipe_t;

  // Register write from EX, also the forwarding source
  typedef struct packed {
    logic                           we;
    logic [`MINI_RV_REG_ADDR_W-1:0] waddr;
    logic [`MINI_RV_XLEN-1:0]       wdata;
  } rf_fwd_t;

endpackage

`default_nettype wire

// File: hdl/mini_rv_if_stage.sv
// mini_rv instruction fetch

`timescale 1ns/1ps
`default_nettype none

`include "mini_rv_settings.svh"

module mini_rv_if_stage import mini_rv_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        fetch_enable_i,
  // Wishbone instruction master
  output wb_m2s_t     ibus_o,
  input  wb_s2m_t     ibus_i,
  // Towards decode
  output logic        if_valid_o,
  output if_id_pipe_t if_id_pipe_o,
  input  logic        id_ready_i
);

  fetch_state_e             state_q;
  logic [`MINI_RV_XLEN-1:0] pc_q;
  logic                     if_valid_q;
  if_id_pipe_t              if_id_q;
  // Word that came back while IF/ID was still occupied
  if_id_pipe_t              hold_q;
  if_id_pipe_t              fetched;
  logic                     fetch_ack;
  logic                     slot_free;
  logic                     hold_release;

  assign fetch_ack    = (state_q == FETCH_WAIT) && ibus_i.ack;
  // IF/ID empty, or emptied at this edge
  assign slot_free    = !if_valid_q || id_ready_i;
  assign hold_release = (state_q == FETCH_HOLD) && id_ready_i;

  assign fetched.instr = ibus_i.dat;
  assign fetched.pc    = pc_q;

  // Full word read at the PC
  always_comb begin
    ibus_o     = '0;
    ibus_o.cyc = (state_q == FETCH_WAIT);
    ibus_o.stb = (state_q == FETCH_WAIT);
    ibus_o.adr = pc_q;
    ibus_o.sel = 4'hf;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Fetch FSM and PC
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= FETCH_IDLE;
      pc_q    <= `MINI_RV_BOOT_ADDR;
    end else begin
      case (state_q)
        // Leaving IDLE latches the start request
        FETCH_IDLE: begin
          if (fetch_enable_i) begin
            state_q <= FETCH_WAIT;
          end
        end
        FETCH_WAIT: begin
          if (ibus_i.ack) begin
            pc_q <= pc_q + 32'd4;
            // No room in IF/ID, park the word and stop fetching
            if (!slot_free) begin
              state_q <= FETCH_HOLD;
            end
          end
        end
        FETCH_HOLD: begin
          if (id_ready_i) begin
            state_q <= FETCH_WAIT;
          end
        end
        default: begin
          state_q <= FETCH_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      if_valid_q <= 1'b0;
    end else if ((fetch_ack && slot_free) || hold_release) begin
      if_valid_q <= 1'b1;
    end else if (id_ready_i) begin
      if_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_ack && slot_free) begin
      if_id_q <= fetched;
    end else if (hold_release) begin
      if_id_q <= hold_q;
    end
    if (fetch_ack && !slot_free) begin
      hold_q <= fetched;
    end
  end

  assign if_valid_o   = if_valid_q;
  assign if_id_pipe_o = if_id_q;

  // Bus rules
  a_ibus_adr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    ibus_o.stb && !ibus_i.ack |=> ibus_o.stb && $stable(ibus_o.adr));

  // IF/ID offer held until decode takes it
  a_if_id_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    if_valid_o && !id_ready_i |=> if_valid_o && $stable(if_id_pipe_o));

endmodule

`default_nettype wire

// File: hdl/mini_rv_id_stage.sv
// mini_rv decode and operand forwarding

`timescale 1ns/1ps
`default_nettype none

`include "mini_rv_settings.svh"

module mini_rv_id_stage import mini_rv_pkg::*; (
  input  logic                           clk_i,
  input  logic                           reset_i,
  // From fetch
  input  logic                           if_valid_i,
  input  if_id_pipe_t                    if_id_pipe_i,
  output logic                           id_ready_o,
  // Register file read ports
  output logic [`MINI_RV_REG_ADDR_W-1:0] rs1_addr_o,
  output logic [`MINI_RV_REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [`MINI_RV_XLEN-1:0]       rs1_data_i,
  input  logic [`MINI_RV_XLEN-1:0]       rs2_data_i,
  // Result of the instruction in EX
  input  rf_fwd_t                        ex_fwd_i,
  // Towards execute
  output logic                           id_valid_o,
  output id_ex_pipe_t                    id_ex_pipe_o,
  input  logic                           ex_ready_i
);

  // Major opcodes kept by the core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  logic [`MINI_RV_XLEN-1:0]       instr;
  opcode_e                        opcode;
  logic [2:0]                     funct3;
  logic [6:0]                     funct7;
  logic [`MINI_RV_REG_ADDR_W-1:0] rs1;
  logic [`MINI_RV_REG_ADDR_W-1:0] rs2;
  logic [`MINI_RV_XLEN-1:0]       imm_i;
  logic [`MINI_RV_XLEN-1:0]       imm_s;
  logic [`MINI_RV_XLEN-1:0]       imm_u;
  logic [`MINI_RV_XLEN-1:0]       op_a;
  logic [`MINI_RV_XLEN-1:0]       op_b;
  logic                           fwd_a;
  logic                           fwd_b;
  id_ex_pipe_t                    dec;
  logic                           id_valid_q;
  id_ex_pipe_t                    id_ex_q;

  // Instruction fields
  assign instr  = if_id_pipe_i.instr;
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign rs1_addr_o = rs1;
  assign rs2_addr_o = rs2;

  // I, S and U immediates
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  ////////////////////////////////////////////////////////////////////////////
  // Operand forwarding from EX
  ////////////////////////////////////////////////////////////////////////////

  // x0 never takes a forwarded value
  assign fwd_a = ex_fwd_i.we && (ex_fwd_i.waddr == rs1) && (rs1 != '0);
  assign fwd_b = ex_fwd_i.we && (ex_fwd_i.waddr == rs2) && (rs2 != '0);

  assign op_a = fwd_a ? ex_fwd_i.wdata : rs1_data_i;
  assign op_b = fwd_b ? ex_fwd_i.wdata : rs2_data_i;

  ////////////////////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    dec              = '0;
    dec.kind         = KIND_NOP;
    dec.alu_op       = ALU_ADD;
    dec.operand_a    = op_a;
    dec.operand_b    = op_b;
    dec.store_data   = op_b;
    dec.store_offset = imm_s;
    dec.rd           = instr[11:7];
    case (opcode)
      OPC_OP: begin
        dec.kind = KIND_ALU;
        case (funct3)
          3'b000: dec.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
          3'b010: dec.alu_op = ALU_SLT;
          3'b100: dec.alu_op = ALU_XOR;
          3'b110: dec.alu_op = ALU_OR;
          3'b111: dec.alu_op = ALU_AND;
          default: dec.kind = KIND_NOP;
        endcase
        // funct7 other than zero is only legal for SUB
        if (funct7 != 7'b0 && !(funct7 == 7'b0100000 && funct3 == 3'b000)) begin
          dec.kind = KIND_NOP;
        end
      end
      // ADDI only
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          dec.kind      = KIND_ALU;
          dec.operand_b = imm_i;
        end
      end
      OPC_LUI: begin
        dec.kind      = KIND_ALU;
        dec.alu_op    = ALU_PASS_B;
        dec.operand_b = imm_u;
      end
      // SW only
      OPC_STORE: begin
        if (funct3 == 3'b010) begin
          dec.kind   = KIND_STORE;
          dec.alu_op = ALU_PASS_B;
        end
      end
      default: begin
        dec.kind = KIND_NOP;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////////////////////

  assign id_ready_o = !id_valid_q || ex_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_valid_q <= 1'b0;
    end else if (id_ready_o) begin
      id_valid_q <= if_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (if_valid_i && id_ready_o) begin
      id_ex_q <= dec;
    end
  end

  assign id_valid_o   = id_valid_q;
  assign id_ex_pipe_o = id_ex_q;

endmodule

`default_nettype wire

// File: hdl/mini_rv_register_file.sv
// mini_rv integer register file

`timescale 1ns/1ps
`default_nettype none

`include "mini_rv_settings.svh"

module mini_rv_register_file import mini_rv_pkg::*; (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic [`MINI_RV_REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`MINI_RV_REG_ADDR_W-1:0] raddr_b_i,
  output logic [`MINI_RV_XLEN-1:0]       rdata_a_o,
  output logic [`MINI_RV_XLEN-1:0]       rdata_b_o,
  input  rf_fwd_t                        wr_i
);

  // x1 to x31, x0 has no storage
  logic [`MINI_RV_XLEN-1:0] regs_q [1:`MINI_RV_NUM_REGS-1];

  // Single write port, x0 writes dropped
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < `MINI_RV_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.we && wr_i.waddr != '0) begin
      regs_q[wr_i.waddr] <= wr_i.wdata;
    end
  end

  // Combinational reads
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// File: hdl/mini_rv_ex_stage.sv
// mini_rv execute and write-back

`timescale 1ns/1ps
`default_nettype none

`include "mini_rv_settings.svh"

module mini_rv_ex_stage import mini_rv_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  // Instruction held in ID/EX
  input  logic        id_valid_i,
  input  id_ex_pipe_t id_ex_pipe_i,
  output logic        ex_ready_o,
  // Register write, forwarded to decode as well
  output rf_fwd_t     ex_fwd_o,
  // Wishbone data master
  output wb_m2s_t     dbus_o,
  input  wb_s2m_t     dbus_i
);

  logic [`MINI_RV_XLEN-1:0] alu_a;
  logic [`MINI_RV_XLEN-1:0] alu_b;
  logic [`MINI_RV_XLEN-1:0] alu_result;
  logic                     is_alu;
  logic                     is_store;

  assign alu_a    = id_ex_pipe_i.operand_a;
  assign alu_b    = id_ex_pipe_i.operand_b;
  assign is_alu   = id_valid_i && (id_ex_pipe_i.kind == KIND_ALU);
  assign is_store = id_valid_i && (id_ex_pipe_i.kind == KIND_STORE);

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex_pipe_i.alu_op)
      ALU_ADD:    alu_result = alu_a + alu_b;
      ALU_SUB:    alu_result = alu_a - alu_b;
      ALU_AND:    alu_result = alu_a & alu_b;
      ALU_OR:     alu_result = alu_a | alu_b;
      ALU_XOR:    alu_result = alu_a ^ alu_b;
      // Signed compare, result is 0 or 1
      ALU_SLT: begin
        alu_result = {{(`MINI_RV_XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
      end
      ALU_PASS_B: alu_result = alu_b;
      default:    alu_result = '0;
    endcase
  end

  // Written at the next edge, x0 never
  assign ex_fwd_o.we    = is_alu && (id_ex_pipe_i.rd != '0);
  assign ex_fwd_o.waddr = id_ex_pipe_i.rd;
  assign ex_fwd_o.wdata = alu_result;

  ////////////////////////////////////////////////////////////////////////////
  // Store over the data bus
  ////////////////////////////////////////////////////////////////////////////

  // Full-word write, held until ack
  always_comb begin
    dbus_o     = '0;
    dbus_o.cyc = is_store;
    dbus_o.stb = is_store;
    dbus_o.we  = 1'b1;
    dbus_o.sel = 4'hf;
    dbus_o.adr = alu_a + id_ex_pipe_i.store_offset;
    dbus_o.dat = id_ex_pipe_i.store_data;
  end

  // A store leaves EX on its ack cycle, everything else in one cycle
  assign ex_ready_o = !is_store || dbus_i.ack;

  // Request stays put while the slave stalls
  a_dbus_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    dbus_o.stb && !dbus_i.ack |=>
      dbus_o.stb && $stable(dbus_o.adr) && $stable(dbus_o.dat));

endmodule

`default_nettype wire

// File: hdl/mini_rv_core.sv
// mini_rv core top level

`timescale 1ns/1ps
`default_nettype none

`include "mini_rv_settings.svh"

module mini_rv_core import mini_rv_pkg::*; (
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    fetch_enable_i,
  // Wishbone instruction bus
  output wb_m2s_t ibus_o,
  input  wb_s2m_t ibus_i,
  // Wishbone data bus
  output wb_m2s_t dbus_o,
  input  wb_s2m_t dbus_i
);

  // IF to ID
  logic                           if_valid;
  if_id_pipe_t                    if_id_pipe;
  logic                           id_ready;

  // ID to EX
  logic                           id_valid;
  id_ex_pipe_t                    id_ex_pipe;
  logic                           ex_ready;

  // Register file reads and the EX write
  logic [`MINI_RV_REG_ADDR_W-1:0] rs1_addr;
  logic [`MINI_RV_REG_ADDR_W-1:0] rs2_addr;
  logic [`MINI_RV_XLEN-1:0]       rs1_data;
  logic [`MINI_RV_XLEN-1:0]       rs2_data;
  rf_fwd_t                        ex_fwd;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////////////////////////////////////////

  mini_rv_if_stage if_stage_inst (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fetch_enable_i (fetch_enable_i),
    .ibus_o         (ibus_o),
    .ibus_i         (ibus_i),
    .if_valid_o     (if_valid),
    .if_id_pipe_o   (if_id_pipe),
    .id_ready_i     (id_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Decode and registers
  ////////////////////////////////////////////////////////////////////////////

  mini_rv_id_stage id_stage_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .if_valid_i   (if_valid),
    .if_id_pipe_i (if_id_pipe),
    .id_ready_o   (id_ready),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .ex_fwd_i     (ex_fwd),
    .id_valid_o   (id_valid),
    .id_ex_pipe_o (id_ex_pipe),
    .ex_ready_i   (ex_ready)
  );

  // Write port fed straight from EX
  mini_rv_register_file register_file_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .raddr_a_i (rs1_addr),
    .raddr_b_i (rs2_addr),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data),
    .wr_i      (ex_fwd)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Execute and write-back
  ////////////////////////////////////////////////////////////////////////////

  mini_rv_ex_stage ex_stage_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .id_valid_i   (id_valid),
    .id_ex_pipe_i (id_ex_pipe),
    .ex_ready_o   (ex_ready),
    .ex_fwd_o     (ex_fwd),
    .dbus_o       (dbus_o),
    .dbus_i       (dbus_i)
  );

endmodule

`default_nettype wire

// File: testbench/mini_rv_tb.sv
// mini_rv core testbench

`timescale 1ns/1ps
`default_nettype none

`include "mini_rv_settings.svh"

module mini_rv_tb import mini_rv_pkg::*; ;

  // Program shape
  localparam int N_RAND      = 48;
  localparam int N_STORE     = 32;
  localparam int N_PROG      = N_RAND + N_STORE;
  localparam int CYCLE_LIMIT = 40 * N_PROG;
  localparam logic [31:0] STORE_BASE = 32'h0000_0100;
  localparam logic [31:0] NOP_WORD   = 32'h0000_0013;

  // Operation codes of the program table
  localparam logic [3:0] OP_ADD  = 4'd0;
  localparam logic [3:0] OP_SUB  = 4'd1;
  localparam logic [3:0] OP_AND  = 4'd2;
  localparam logic [3:0] OP_OR   = 4'd3;
  localparam logic [3:0] OP_XOR  = 4'd4;
  localparam logic [3:0] OP_SLT  = 4'd5;
  localparam logic [3:0] OP_ADDI = 4'd6;
  localparam logic [3:0] OP_LUI  = 4'd7;
  localparam logic [3:0] OP_SW   = 4'd8;

  logic    clk = 1'b0;
  logic    reset;
  logic    fetch_enable;
  wb_m2s_t ibus_req;
  wb_s2m_t ibus_rsp = '0;
  wb_m2s_t dbus_req;
  wb_s2m_t dbus_rsp = '0;

  integer      seed;
  logic [3:0]  prog_op   [0:N_PROG-1];
  logic [4:0]  prog_rd   [0:N_PROG-1];
  logic [4:0]  prog_rs1  [0:N_PROG-1];
  logic [4:0]  prog_rs2  [0:N_PROG-1];
  logic [31:0] prog_imm  [0:N_PROG-1];
  logic [31:0] prog_word [0:N_PROG-1];
  wb_m2s_t     exp_q     [$];

  logic [1:0]  ibus_wait   = 2'd0;
  logic [1:0]  dbus_wait   = 2'd0;
  logic [31:0] exp_fetch   = `MINI_RV_BOOT_ADDR;
  int          n_matched   = 0;
  logic        stores_done = 1'b0;
  int          cycles      = 0;

  mini_rv_core mini_rv_core_inst (
    .clk_i          (clk),
    .reset_i        (reset),
    .fetch_enable_i (fetch_enable),
    .ibus_o         (ibus_req),
    .ibus_i         (ibus_rsp),
    .dbus_o         (dbus_req),
    .dbus_i         (dbus_rsp)
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Failure reporting and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_addr(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL %0t: ibus adr %h, expected %h", $time, got, exp));
    end
  endtask

  task automatic check_store(input wb_m2s_t got, input wb_m2s_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL %0t: store adr %h dat %h we %b sel %h, expected adr %h dat %h",
        $time, got.adr, got.dat, got.we, got.sel, exp.adr, exp.dat));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Program generation and reference model
  ////////////////////////////////////////////////////////////////////////////

  // RV32I encodings of the kept instructions
  function automatic logic [31:0] encode(input logic [3:0] op, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [31:0] imm);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = 3'b000;
    f7 = 7'b0;
    case (op)
      OP_SUB:  f7 = 7'b0100000;
      OP_AND:  f3 = 3'b111;
      OP_OR:   f3 = 3'b110;
      OP_XOR:  f3 = 3'b100;
      OP_SLT:  f3 = 3'b010;
      default: f3 = 3'b000;
    endcase
    case (op)
      OP_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
      OP_LUI:  return {imm[31:12], rd, 7'b0110111};
      OP_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
      default: return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endcase
  endfunction

  task automatic generate_program();
    logic [31:0] r;
    logic [4:0]  prev_rd;
    prev_rd = 5'd0;
    for (int i = 0; i < N_RAND; i++) begin
      r = $random(seed);
      prog_op[i]  = {1'b0, r[2:0]};
      prog_rd[i]  = r[7:3];
      prog_rs1[i] = r[12:8];
      prog_rs2[i] = r[17:13];
      // Seed registers with LUI and ADDI first
      if (i < 8) begin
        prog_op[i] = r[0] ? OP_ADDI : OP_LUI;
      end
      // Back-to-back dependencies exercise forwarding
      if (r[18]) begin
        prog_rs1[i] = prev_rd;
      end
      if (i % 3 == 0) begin
        prog_rs2[i] = prev_rd;
      end
      // Some writes to x0
      if (i % 8 == 5) begin
        prog_rd[i] = 5'd0;
      end
      r = $random(seed);
      prog_imm[i] = (prog_op[i] == OP_LUI) ? {r[31:12], 12'b0} : {{20{r[11]}}, r[11:0]};
      prog_word[i] = encode(prog_op[i], prog_rd[i], prog_rs1[i], prog_rs2[i], prog_imm[i]);
      prev_rd = prog_rd[i];
    end
    // One SW per register, x0 included, to consecutive words
    for (int s = 0; s < N_STORE; s++) begin
      prog_op[N_RAND + s]   = OP_SW;
      prog_rd[N_RAND + s]   = 5'd0;
      prog_rs1[N_RAND + s]  = 5'd0;
      prog_rs2[N_RAND + s]  = s[4:0];
      prog_imm[N_RAND + s]  = STORE_BASE + (s << 2);
      prog_word[N_RAND + s] = encode(OP_SW, 5'd0, 5'd0, s[4:0], STORE_BASE + (s << 2));
    end
  endtask

  // Runs the program in order and queues the expected stores
  function automatic void compute_expected();
    logic [31:0] regs [0:31];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    wb_m2s_t     entry;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    for (int i = 0; i < N_PROG; i++) begin
      a   = regs[prog_rs1[i]];
      b   = regs[prog_rs2[i]];
      res = '0;
      case (prog_op[i])
        OP_ADD:  res = a + b;
        OP_SUB:  res = a - b;
        OP_AND:  res = a & b;
        OP_OR:   res = a | b;
        OP_XOR:  res = a ^ b;
        OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        OP_ADDI: res = a + prog_imm[i];
        OP_LUI:  res = prog_imm[i];
        default: res = '0;
      endcase
      if (prog_op[i] == OP_SW) begin
        entry     = '0;
        entry.cyc = 1'b1;
        entry.stb = 1'b1;
        entry.we  = 1'b1;
        entry.sel = 4'hf;
        entry.adr = a + prog_imm[i];
        entry.dat = b;
        exp_q.push_back(entry);
      end else if (prog_rd[i] != 5'd0) begin
        regs[prog_rd[i]] = res;
      end
    end
  endfunction

  // Past the program the core fetches NOPs
  function automatic logic [31:0] fetch_word(input logic [31:0] adr);
    logic [31:0] offs;
    offs = adr - `MINI_RV_BOOT_ADDR;
    if (adr >= `MINI_RV_BOOT_ADDR && (offs >> 2) < N_PROG) begin
      return prog_word[offs >> 2];
    end
    return NOP_WORD;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus slaves, 0 to 3 wait states each
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic [31:0] r;
    #1;
    ibus_rsp.ack = 1'b0;
    if (!reset && ibus_req.cyc && ibus_req.stb) begin
      if (ibus_wait == 2'd0) begin
        ibus_rsp.ack = 1'b1;
        ibus_rsp.dat = fetch_word(ibus_req.adr);
        r = $random(seed);
        ibus_wait = r[1:0];
      end else begin
        ibus_wait = ibus_wait - 2'd1;
      end
    end
    dbus_rsp.ack = 1'b0;
    if (!reset && dbus_req.cyc && dbus_req.stb) begin
      if (dbus_wait == 2'd0) begin
        dbus_rsp.ack = 1'b1;
        r = $random(seed);
        dbus_wait = r[1:0];
      end else begin
        dbus_wait = dbus_wait - 2'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Monitors and compare
  ////////////////////////////////////////////////////////////////////////////

  // Fetch addresses start at boot and step by 4
  always @(negedge clk) begin
    if (!reset && ibus_req.stb) begin
      // Every fetch is a full-word read inside a bus cycle
      if (!ibus_req.cyc || ibus_req.we || ibus_req.sel != 4'hf) begin
        report_failure($sformatf("FAIL %0t: ibus request is not a full-word read", $time));
      end
      check_addr(ibus_req.adr, exp_fetch);
      if (ibus_rsp.ack) begin
        exp_fetch = exp_fetch + 32'd4;
      end
    end
  end

  always @(negedge clk) begin
    if (!reset && dbus_req.stb && dbus_rsp.ack) begin
      if (exp_q.size() == 0) begin
        report_failure($sformatf("Store to %h at %0t was not expected", dbus_req.adr, $time));
      end else begin
        check_store(dbus_req, exp_q.pop_front());
        n_matched = n_matched + 1;
        if (n_matched == N_STORE) begin
          stores_done = 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, %0d of %0d stores seen", cycles, n_matched, N_STORE);
      $display("Testbench failed");
      $fatal(1, "Run hit the cycle limit");
    end
  end

  initial begin
    reset        = 1'b1;
    fetch_enable = 1'b0;
    seed         = 32'hee8d_54c9;
    generate_program();
    compute_expected();
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    // No fetch while fetch enable is low
    repeat (10) begin
      @(negedge clk);
      if (ibus_req.cyc) begin
        report_failure("The ibus cycle started while fetch_enable_i was still low");
      end
    end
    @(posedge clk);
    #1;
    fetch_enable = 1'b1;
    wait (stores_done);
    // Trailing NOPs must not store
    repeat (20) @(posedge clk);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: mini_rv.f
+incdir+hdl
hdl/mini_rv_pkg.sv
hdl/mini_rv_if_stage.sv
hdl/mini_rv_id_stage.sv
hdl/mini_rv_register_file.sv
hdl/mini_rv_ex_stage.sv
hdl/mini_rv_core.sv
testbench/mini_rv_tb.sv

// File: Makefile
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Mdir $(OBJ_DIR) --top-module mini_rv_tb -f mini_rv.f
	./$(OBJ_DIR)/Vmini_rv_tb

clean:
	rm -rf $(OBJ_DIR)
